// File: biquad_top.sv
`timescale 1ns/10ps
`default_nettype none

// biquad section with bus-programmable coefficients
module biquad_top
	import filter_pkg::*;
	import regmap_pkg::*;
(
	input  wire             clk,
	input  wire             nreset,

	// coefficient bus
	input  wire             stb_i,
	input  wire             we_i,
	input  wire bus_addr_t  adr_i,
	input  wire bus_word_t  dat_i,
	output bus_word_t       dat_o,
	output logic            ack_o,

	// sample stream
	input  wire             valid_i,
	input  wire sample_t    x_i,
	output sample_t         y_o,
	output logic            y_valid_o
);

	// partial sums into the output stage
	acc_t ff_sum;
	logic ff_valid;
	acc_t fb_sum;

	// truncated coefficients
	coef_if coef_bus ();

	coef_regs u_coef_regs (
		.clk    (clk),
		.nreset (nreset),
		.stb_i  (stb_i),
		.we_i   (we_i),
		.adr_i  (adr_i),
		.dat_i  (dat_i),
		.dat_o  (dat_o),
		.ack_o  (ack_o),
		.coef   (coef_bus.regs)
	);

	feedforward_taps u_ff_taps (
		.clk        (clk),
		.nreset     (nreset),
		.valid_i    (valid_i),
		.x_i        (x_i),
		.coef       (coef_bus.ff),
		.ff_sum_o   (ff_sum),
		.ff_valid_o (ff_valid)
	);

	// outputs loop straight back into the pole section
	feedback_taps u_fb_taps (
		.clk       (clk),
		.nreset    (nreset),
		.y_i       (y_o),
		.y_valid_i (y_valid_o),
		.coef      (coef_bus.fb),
		.fb_sum_o  (fb_sum)
	);

	output_stage u_output_stage (
		.clk        (clk),
		.nreset     (nreset),
		.ff_sum_i   (ff_sum),
		.ff_valid_i (ff_valid),
		.fb_sum_i   (fb_sum),
		.y_o        (y_o),
		.y_valid_o  (y_valid_o)
	);

endmodule

`default_nettype wire

// File: coef_if.sv
`timescale 1ns/10ps
`default_nettype none

// the five truncated coefficients between register file and taps
interface coef_if
	import filter_pkg::*;
();

	// pole coefficients
	coef_t a11;
	coef_t a12;

	// zero coefficients
	coef_t b10;
	coef_t b11;
	coef_t b12;

	// register file drives every coefficient
	modport regs (output a11, a12, b10, b11, b12);

	// feedforward taps only need the zeros
	modport ff (input b10, b11, b12);

	// feedback taps only need the poles
	modport fb (input a11, a12);

endinterface

`default_nettype wire

// File: coef_regs.sv
`timescale 1ns/10ps
`default_nettype none

// bus register file holding the five filter coefficients
module coef_regs
	import filter_pkg::*;
	import regmap_pkg::*;
(
	input  wire             clk,
	input  wire             nreset,
	input  wire             stb_i,
	input  wire             we_i,
	input  wire bus_addr_t  adr_i,
	input  wire bus_word_t  dat_i,
	output bus_word_t       dat_o,
	output logic            ack_o,
	coef_if.regs            coef
);

	// full 16-bit words as written by the bus
	bus_word_t a11_q;
	bus_word_t a12_q;
	bus_word_t b10_q;
	bus_word_t b11_q;
	bus_word_t b12_q;

	// single-cycle slave, ack mirrors the strobe
	assign ack_o = stb_i;

	// write on any edge with strobe and write enable high
	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			a11_q <= COEF_RESET;
			a12_q <= COEF_RESET;
			b10_q <= COEF_RESET;
			b11_q <= COEF_RESET;
			b12_q <= COEF_RESET;
		end
		else if (stb_i && we_i)
		begin
			case (adr_i)
				ADDR_A11: a11_q <= dat_i;
				ADDR_A12: a12_q <= dat_i;
				ADDR_B10: b10_q <= dat_i;
				ADDR_B11: b11_q <= dat_i;
				ADDR_B12: b12_q <= dat_i;
				// unused addresses swallow the write
				default: ;
			endcase
		end
	end

	// read back the whole word, not the truncated coefficient
	always_comb
	begin
		case (adr_i)
			ADDR_A11: dat_o = a11_q;
			ADDR_A12: dat_o = a12_q;
			ADDR_B10: dat_o = b10_q;
			ADDR_B11: dat_o = b11_q;
			ADDR_B12: dat_o = b12_q;
			default:  dat_o = RDATA_UNUSED;
		endcase
	end

	// filter sees only the top COEF_W bits, low bits are dropped
	assign coef.a11 = a11_q[BUS_W-1 -: COEF_W];
	assign coef.a12 = a12_q[BUS_W-1 -: COEF_W];
	assign coef.b10 = b10_q[BUS_W-1 -: COEF_W];
	assign coef.b11 = b11_q[BUS_W-1 -: COEF_W];
	assign coef.b12 = b12_q[BUS_W-1 -: COEF_W];

endmodule

`default_nettype wire

// File: feedback_taps.sv
`timescale 1ns/10ps
`default_nettype none

// pole section: output history and combinational sum of the two a terms
module feedback_taps
	import filter_pkg::*;
(
	input  wire           clk,
	input  wire           nreset,
	input  wire sample_t  y_i,
	input  wire           y_valid_i,
	coef_if.fb            coef,
	output acc_t          fb_sum_o
);

	// captured outputs, shifted one cycle after each new output
	sample_t y_m1;
	sample_t y_m2;

	// the two past outputs the next sample must see
	sample_t y_prev1;
	sample_t y_prev2;

	// newest output always sits on y_i, the stage holds it between samples
	assign y_prev1 = y_i;

	// while y_valid_i is high the fresh output is not shifted in yet,
	// so the older one is still in y_m1
	assign y_prev2 = y_valid_i ? y_m1 : y_m2;

	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			y_m1 <= '0;
			y_m2 <= '0;
		end
		else if (y_valid_i)
		begin
			y_m1 <= y_i;
			y_m2 <= y_m1;
		end
	end

	// feedback terms are added, the coefficient carries the sign
	assign fb_sum_o = acc_t'(coef.a11 * y_prev1) + acc_t'(coef.a12 * y_prev2);

endmodule

`default_nettype wire

// File: feedforward_taps.sv
`timescale 1ns/10ps
`default_nettype none

// zero section: input history and registered sum of the three b terms
module feedforward_taps
	import filter_pkg::*;
(
	input  wire           clk,
	input  wire           nreset,
	input  wire           valid_i,
	input  wire sample_t  x_i,
	coef_if.ff            coef,
	output acc_t          ff_sum_o,
	output logic          ff_valid_o
);

	// x[n-1] and x[n-2]
	sample_t x_m1;
	sample_t x_m2;

	// signed products, sign extended to the accumulator width
	acc_t prod_b10;
	acc_t prod_b11;
	acc_t prod_b12;

	assign prod_b10 = coef.b10 * x_i;
	assign prod_b11 = coef.b11 * x_m1;
	assign prod_b12 = coef.b12 * x_m2;

	// history advances only on accepted samples
	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			x_m1 <= '0;
			x_m2 <= '0;
		end
		else if (valid_i)
		begin
			x_m1 <= x_i;
			x_m2 <= x_m1;
		end
	end

	// partial sum held until the next sample, valid is a one-cycle pulse
	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			ff_sum_o   <= '0;
			ff_valid_o <= 1'b0;
		end
		else
		begin
			ff_valid_o <= valid_i;
			if (valid_i)
			begin
				ff_sum_o <= prod_b10 + prod_b11 + prod_b12;
			end
		end
	end

endmodule

`default_nettype wire

// File: filter_pkg.sv
`default_nettype none

// datapath widths and number formats of the biquad section
package filter_pkg;

	// sample width, signed two's complement fraction
	localparam int DATA_W = 8;

	// coefficient width, top bits of each 16-bit bus register
	localparam int COEF_W = 8;

	// three guard bits hold the sum of five full products
	localparam int ACC_W = DATA_W + COEF_W + 3;

	// products carry COEF_W-1 fraction bits from the coefficient
	localparam int FRAC_SHIFT = COEF_W - 1;

	typedef logic signed [DATA_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [ACC_W-1:0]  acc_t;

	// output clamp limits, most positive and most negative sample
	localparam sample_t SAMPLE_MAX = sample_t'((2 ** (DATA_W - 1)) - 1);
	localparam sample_t SAMPLE_MIN = sample_t'(-(2 ** (DATA_W - 1)));

endpackage

`default_nettype wire

// File: output_stage.sv
`timescale 1ns/10ps
`default_nettype none

// combines both partial sums, rescales, clamps and registers the output
module output_stage
	import filter_pkg::*;
(
	input  wire         clk,
	input  wire         nreset,
	input  wire acc_t   ff_sum_i,
	input  wire         ff_valid_i,
	input  wire acc_t   fb_sum_i,
	output sample_t     y_o,
	output logic        y_valid_o
);

	acc_t    acc_sum;
	acc_t    acc_scaled;
	sample_t y_sat;

	assign acc_sum = ff_sum_i + fb_sum_i;

	// drop the coefficient fraction bits, floors toward minus infinity
	assign acc_scaled = acc_sum >>> FRAC_SHIFT;

	// clamp to the sample range
	always_comb
	begin
		if (acc_scaled > SAMPLE_MAX)
			y_sat = SAMPLE_MAX;
		else if (acc_scaled < SAMPLE_MIN)
			y_sat = SAMPLE_MIN;
		else
			y_sat = sample_t'(acc_scaled);
	end

	// y_o holds its value between samples, feedback taps rely on that
	always_ff @(posedge clk or negedge nreset)
	begin
		if (!nreset)
		begin
			y_o       <= '0;
			y_valid_o <= 1'b0;
		end
		else
		begin
			y_valid_o <= ff_valid_i;
			if (ff_valid_i)
				y_o <= y_sat;
		end
	end

endmodule

`default_nettype wire

// File: regmap_pkg.sv
`default_nettype none

// bus side of the coefficient register file
package regmap_pkg;

	// bus data word and address widths
	localparam int BUS_W  = 16;
	localparam int ADDR_W = 3;

	typedef logic [BUS_W-1:0]  bus_word_t;
	typedef logic [ADDR_W-1:0] bus_addr_t;

	// coefficient address map, addresses 5 to 7 are unused
	localparam bus_addr_t ADDR_A11 = 3'd0;
	localparam bus_addr_t ADDR_A12 = 3'd1;
	localparam bus_addr_t ADDR_B10 = 3'd2;
	localparam bus_addr_t ADDR_B11 = 3'd3;
	localparam bus_addr_t ADDR_B12 = 3'd4;

	// value read back from an unused address
	localparam bus_word_t RDATA_UNUSED = '0;

	// every coefficient starts out as zero
	localparam bus_word_t COEF_RESET = '0;

endpackage

`default_nettype wire

// File: tb_biquad.sv
`timescale 1ns/10ps
`default_nettype none

// self-checking testbench for the biquad section
module tb_biquad
	import filter_pkg::*;
	import regmap_pkg::*;
();

	localparam int Y_MAX = (1 << (DATA_W - 1)) - 1;
	localparam int Y_MIN = -(1 << (DATA_W - 1));
	// cycles allowed for the pipeline to empty
	localparam int DRAIN_LIMIT = 20;

	logic      clk;
	logic      nreset;
	logic      stb_i;
	logic      we_i;
	bus_addr_t adr_i;
	bus_word_t dat_i;
	bus_word_t dat_o;
	logic      ack_o;
	logic      valid_i;
	sample_t   x_i;
	sample_t   y_o;
	logic      y_valid_o;

	// reference model state with written words and past samples
	bus_word_t coef_word [5];
	int        x_m1;
	int        x_m2;
	int        y_m1;
	int        y_m2;
	int        expected_q [$];
	int        seed = 24214;
	// DUT outputs seen at either clamp limit
	int        hi_seen;
	int        lo_seen;

	biquad_top UUT (
		.clk       (clk),
		.nreset    (nreset),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.dat_o     (dat_o),
		.ack_o     (ack_o),
		.valid_i   (valid_i),
		.x_i       (x_i),
		.y_o       (y_o),
		.y_valid_o (y_valid_o)
	);

	always #50 clk = ~clk;

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// coefficient seen by the filter is the top COEF_W bits of the word
	function automatic int top_coef(input bus_word_t word);
		return int'($signed(word[BUS_W-1 -: COEF_W]));
	endfunction

	function automatic bus_word_t expected_read(input int addr);
		if (addr < 5)
			return coef_word[addr];
		return '0;
	endfunction

	// y = sat((b10 x0 + b11 x1 + b12 x2 + a11 y1 + a12 y2) >>> (COEF_W-1))
	task automatic predict_sample(input int x);
		int acc;
		int y;
		acc = top_coef(coef_word[ADDR_B10]) * x + top_coef(coef_word[ADDR_B11]) * x_m1
			+ top_coef(coef_word[ADDR_B12]) * x_m2 + top_coef(coef_word[ADDR_A11]) * y_m1
			+ top_coef(coef_word[ADDR_A12]) * y_m2;
		y = acc >>> (COEF_W - 1);
		if (y > Y_MAX)
			y = Y_MAX;
		else if (y < Y_MIN)
			y = Y_MIN;
		x_m2 = x_m1;
		x_m1 = x;
		y_m2 = y_m1;
		y_m1 = y;
		expected_q.push_back(y);
	endtask

	task automatic bus_write(input bus_addr_t addr, input bus_word_t word);
		@(negedge clk);
		stb_i = 1'b1;
		we_i  = 1'b1;
		adr_i = addr;
		dat_i = word;
		if (addr < 5)
			coef_word[addr] = word;
		@(posedge clk);
	endtask

	// combinational read, no write happens at this edge
	task automatic bus_check(input int addr);
		@(negedge clk);
		stb_i = 1'b1;
		we_i  = 1'b0;
		adr_i = bus_addr_t'(addr);
		@(posedge clk);
		assert (dat_o == expected_read(addr))
		else stop_on_error($sformatf("Mismatch at %0t: address %0d read %h, expected %h",
			$time, addr, dat_o, expected_read(addr)));
	endtask

	task automatic send_sample(input sample_t x);
		@(negedge clk);
		valid_i = 1'b1;
		x_i     = x;
		predict_sample(int'(x));
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			valid_i = 1'b0;
			stb_i   = 1'b0;
			we_i    = 1'b0;
		end
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0 && cycles < DRAIN_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		if (expected_q.size() != 0)
			stop_on_error("timed out waiting for the filter outputs");
	endtask

	// every sample gives exactly one output two edges later
	assert property (@(posedge clk) disable iff (!nreset) valid_i |-> ##2 y_valid_o)
	else stop_on_error($sformatf("Mismatch at %0t: no output two edges after a sample", $time));

	assert property (@(posedge clk) disable iff (!nreset) y_valid_o |-> $past(valid_i, 2))
	else stop_on_error($sformatf("Mismatch at %0t: output without a sample before", $time));

	assert property (@(posedge clk) ack_o == stb_i)
	else stop_on_error($sformatf("Mismatch at %0t: ack_o does not follow stb_i", $time));

	// registered outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (nreset && y_valid_o)
		begin
			assert (expected_q.size() > 0)
			else stop_on_error("an output appeared with no sample pending");
			assert (y_o == sample_t'(expected_q[0]))
			else stop_on_error($sformatf("Mismatch at %0t: y_o %0d, expected %0d",
				$time, y_o, expected_q[0]));
			void'(expected_q.pop_front());
			// count outputs that the DUT clamped
			if (y_o == sample_t'(Y_MAX))
				hi_seen++;
			if (y_o == sample_t'(Y_MIN))
				lo_seen++;
		end
	end

	initial
	begin
		clk     = 1'b0;
		nreset  = 1'b0;
		stb_i   = 1'b0;
		we_i    = 1'b0;
		adr_i   = '0;
		dat_i   = '0;
		valid_i = 1'b0;
		x_i     = '0;
		foreach (coef_word[i])
			coef_word[i] = '0;
		x_m1    = 0;
		x_m2    = 0;
		y_m1    = 0;
		y_m2    = 0;
		hi_seen = 0;
		lo_seen = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		nreset = 1'b1;

		// reset state
		assert (y_o == '0 && y_valid_o == 1'b0)
		else stop_on_error($sformatf("Mismatch at %0t: output not cleared by reset", $time));
		for (int a = 0; a < 5; a++)
			bus_check(a);

		// full words read back and unused addresses read zero
		bus_write(ADDR_A11, 16'h1234);
		bus_write(ADDR_A12, 16'habcd);
		bus_write(ADDR_B10, 16'h8001);
		bus_write(ADDR_B11, 16'h7ffe);
		bus_write(ADDR_B12, 16'h0f0f);
		for (int a = 0; a < 8; a++)
			bus_check(a);
		// single writes leave the other registers alone
		bus_write(ADDR_B10, 16'h5a5a);
		bus_write(3'd6, 16'hffff);
		for (int a = 0; a < 8; a++)
			bus_check(a);
		idle(1);

		// zeros only and the low bits of each word must not matter
		bus_write(ADDR_A11, 16'h00ff);
		bus_write(ADDR_A12, 16'h0080);
		bus_write(ADDR_B10, 16'h40ff);
		bus_write(ADDR_B11, 16'h207f);
		bus_write(ADDR_B12, 16'he081);
		idle(1);
		send_sample(SAMPLE_MAX);
		repeat (4) send_sample('0);
		idle(1);
		wait_for_drain();

		// poles on with random samples back to back
		bus_write(ADDR_A11, 16'h5000);
		bus_write(ADDR_A12, 16'hd800);
		bus_write(ADDR_B10, 16'h3000);
		bus_write(ADDR_B11, 16'h2000);
		bus_write(ADDR_B12, 16'h1000);
		idle(1);
		repeat (40) send_sample(sample_t'($random(seed)));
		idle(1);
		wait_for_drain();
		// then with random gaps where a zero gap keeps valid_i high
		repeat (40)
		begin
			send_sample(sample_t'($random(seed)));
			idle($unsigned($random(seed)) % 4);
		end
		idle(1);
		wait_for_drain();

		// large gains on full-scale input drive the clamp both ways
		bus_write(ADDR_A11, 16'h7f00);
		bus_write(ADDR_A12, 16'h0000);
		bus_write(ADDR_B10, 16'h7f00);
		bus_write(ADDR_B11, 16'h7f00);
		bus_write(ADDR_B12, 16'h7f00);
		idle(1);
		repeat (6) send_sample(SAMPLE_MAX);
		repeat (6) send_sample(SAMPLE_MIN);
		idle(1);
		wait_for_drain();

		if (hi_seen > 0 && lo_seen > 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			stop_on_error("the output never reached both saturation limits");
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
filter_pkg.sv
regmap_pkg.sv
coef_if.sv
coef_regs.sv
feedforward_taps.sv
feedback_taps.sv
output_stage.sv
biquad_top.sv
tb_biquad.sv
